// ==== hw/rv_decode_pkg.sv ====
package rv_decode_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [31:0] word_t;
    // word aligned, low two bits dropped
    typedef logic [31:2] pc_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [4:0]  opgrp_t;
    // bit 4 selects arithmetic right shift
    typedef logic [4:0]  alu_ctrl_t;
    typedef logic [1:0]  res_src_t;

    // opcode groups, instruction bits 6:2
    localparam opgrp_t OPG_LOAD     = 5'b00000;
    localparam opgrp_t OPG_MISC_MEM = 5'b00011;
    localparam opgrp_t OPG_OP_IMM   = 5'b00100;
    localparam opgrp_t OPG_AUIPC    = 5'b00101;
    localparam opgrp_t OPG_STORE    = 5'b01000;
    localparam opgrp_t OPG_OP       = 5'b01100;
    localparam opgrp_t OPG_LUI      = 5'b01101;
    localparam opgrp_t OPG_BRANCH   = 5'b11000;
    localparam opgrp_t OPG_JALR     = 5'b11001;
    localparam opgrp_t OPG_JAL      = 5'b11011;
    localparam opgrp_t OPG_SYSTEM   = 5'b11100;

    // alu operation codes, low four bits of alu_ctrl_t
    localparam logic [3:0] ALU_ADD      = 4'b0000;
    localparam logic [3:0] ALU_SUB      = 4'b0001;
    localparam logic [3:0] ALU_XOR      = 4'b0010;
    localparam logic [3:0] ALU_OR       = 4'b0011;
    localparam logic [3:0] ALU_AND      = 4'b0100;
    localparam logic [3:0] ALU_SHL      = 4'b0101;
    localparam logic [3:0] ALU_SHR      = 4'b0110;
    localparam logic [3:0] ALU_CMP_EQ   = 4'b1000;
    localparam logic [3:0] ALU_CMP_NEQ  = 4'b1001;
    localparam logic [3:0] ALU_CMP_LTS  = 4'b1010;
    localparam logic [3:0] ALU_CMP_LTU  = 4'b1011;
    localparam logic [3:0] ALU_CMP_NLTS = 4'b1100;
    localparam logic [3:0] ALU_CMP_NLTU = 4'b1101;

    // writeback source
    localparam res_src_t RES_SRC_ALU   = 2'b00;
    localparam res_src_t RES_SRC_MEM   = 2'b01;
    localparam res_src_t RES_SRC_PC_P4 = 2'b10;

    // alu operand selects
    localparam logic OP1_SEL_REG = 1'b0;
    localparam logic OP1_SEL_PC  = 1'b1;
    localparam logic OP2_SEL_REG = 1'b0;
    localparam logic OP2_SEL_IMM = 1'b1;

    // legal funct7 values
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

endpackage

// ==== hw/rv_instr_hold.sv ====
`timescale 1ns/1ps

module rv_instr_hold
(
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_stall,
    input  logic                  i_flush,
    input  rv_decode_pkg::instr_t i_data,
    input  rv_decode_pkg::pc_t    i_pc,
    input  rv_decode_pkg::pc_t    i_pc_p4,
    output rv_decode_pkg::instr_t o_instr,
    output rv_decode_pkg::pc_t    o_pc,
    output rv_decode_pkg::pc_t    o_pc_p4
);

    import rv_decode_pkg::*;

    pc_t        r_pc;
    pc_t        r_pc_p4;
    instr_t     r_instr;
    instr_t     r_instr_buf;
    logic       r_flush;
    logic [1:0] r_stall;

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            r_pc    <= '0;
            r_pc_p4 <= '0;
        end
        else if (!i_stall)
        begin
            r_pc    <= i_pc;
            r_pc_p4 <= i_pc_p4;
        end
    end

    // two-deep buffer, frozen once stall history is 11
    always_ff @(posedge i_clk)
    begin
        if (!(&r_stall))
        begin
            r_instr     <= i_data;
            r_instr_buf <= r_instr;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            r_flush <= 1'b0;
            r_stall <= 2'b00;
        end
        else
        begin
            r_flush <= i_flush;
            r_stall <= {r_stall[0] & i_stall, i_stall};
        end
    end

    always_comb
    begin
        if (i_reset || r_flush)
            o_instr = '0;
        else if (!r_stall[0])
            o_instr = i_data;
        else if (!r_stall[1])
            o_instr = r_instr;
        else
            o_instr = r_instr_buf;
    end

    assign o_pc    = r_pc;
    assign o_pc_p4 = r_pc_p4;

endmodule

// ==== hw/rv_instr_class.sv ====
`timescale 1ns/1ps

module rv_instr_class
(
    input  rv_decode_pkg::instr_t   i_instr,
    output rv_decode_pkg::reg_idx_t o_rs1,
    output rv_decode_pkg::reg_idx_t o_rs2,
    output rv_decode_pkg::reg_idx_t o_rd,
    output rv_decode_pkg::funct3_t  o_funct3,
    output logic                    o_is_load,
    output logic                    o_is_store,
    output logic                    o_is_op_imm,
    output logic                    o_is_op_reg,
    output logic                    o_is_branch,
    output logic                    o_is_jal,
    output logic                    o_is_jalr,
    output logic                    o_is_lui,
    output logic                    o_is_auipc,
    output logic                    o_inv_instr
);

    import rv_decode_pkg::*;

    opgrp_t     opgrp;
    funct3_t    funct3;
    logic [6:0] funct7;
    logic       is_full;
    logic       is_none;
    logic       f7_base;
    logic       f7_alt;
    logic       grp_load;
    logic       grp_misc_mem;
    logic       grp_op_imm;
    logic       grp_auipc;
    logic       grp_store;
    logic       grp_op;
    logic       grp_lui;
    logic       grp_branch;
    logic       grp_jalr;
    logic       grp_jal;
    logic       imm_f7_ok;
    logic       reg_f7_ok;
    logic       is_fence;
    logic       supported;

    assign opgrp   = i_instr[6:2];
    assign funct3  = i_instr[14:12];
    assign funct7  = i_instr[31:25];
    // 16-bit compressed words have low bits other than 11
    assign is_full = (i_instr[1:0] == 2'b11);
    assign is_none = (i_instr == '0);
    assign f7_base = (funct7 == FUNCT7_BASE);
    assign f7_alt  = (funct7 == FUNCT7_ALT);

    assign grp_load     = is_full && (opgrp == OPG_LOAD);
    assign grp_misc_mem = is_full && (opgrp == OPG_MISC_MEM);
    assign grp_op_imm   = is_full && (opgrp == OPG_OP_IMM);
    assign grp_auipc    = is_full && (opgrp == OPG_AUIPC);
    assign grp_store    = is_full && (opgrp == OPG_STORE);
    assign grp_op       = is_full && (opgrp == OPG_OP);
    assign grp_lui      = is_full && (opgrp == OPG_LUI);
    assign grp_branch   = is_full && (opgrp == OPG_BRANCH);
    assign grp_jalr     = is_full && (opgrp == OPG_JALR);
    assign grp_jal      = is_full && (opgrp == OPG_JAL);

    // slli needs base funct7, srli/srai base or alt
    assign imm_f7_ok = (funct3 == 3'b001) ? f7_base :
                       (funct3 == 3'b101) ? (f7_base || f7_alt) : 1'b1;
    // alt only for sub and sra
    assign reg_f7_ok = f7_base || (f7_alt && ((funct3 == 3'b000) || (funct3 == 3'b101)));

    // lb lh lw lbu lhu
    assign o_is_load   = grp_load && (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
    // sb sh sw
    assign o_is_store  = grp_store && (funct3 inside {3'b000, 3'b001, 3'b010});
    assign o_is_op_imm = grp_op_imm && imm_f7_ok;
    assign o_is_op_reg = grp_op && reg_f7_ok;
    // funct3 010 and 011 unused for branches
    assign o_is_branch = grp_branch && (funct3 != 3'b010) && (funct3 != 3'b011);
    assign o_is_jalr   = grp_jalr && (funct3 == 3'b000);
    assign o_is_jal    = grp_jal;
    assign o_is_lui    = grp_lui;
    assign o_is_auipc  = grp_auipc;
    // fence and fence.i
    assign is_fence    = grp_misc_mem && ((funct3 == 3'b000) || (funct3 == 3'b001));

    // all-zero word is a bubble, not an error
    assign supported = is_none || o_is_load || o_is_store || o_is_op_imm || o_is_op_reg ||
                       o_is_lui || o_is_auipc || o_is_branch || o_is_jal || o_is_jalr ||
                       is_fence;

    // ecall, ebreak and csr ops are not handled here
    assign o_inv_instr = !supported;

    assign o_rs1    = o_is_lui ? '0 : i_instr[19:15];
    assign o_rs2    = i_instr[24:20];
    assign o_rd     = i_instr[11:7];
    assign o_funct3 = funct3;

endmodule

// ==== hw/rv_imm_gen.sv ====
`timescale 1ns/1ps

module rv_imm_gen
(
    input  rv_decode_pkg::instr_t i_instr,
    input  logic                  i_is_load,
    input  logic                  i_is_store,
    input  logic                  i_is_op_imm,
    input  logic                  i_is_branch,
    input  logic                  i_is_jal,
    input  logic                  i_is_jalr,
    input  logic                  i_is_lui,
    input  logic                  i_is_auipc,
    output rv_decode_pkg::word_t  o_imm
);

    import rv_decode_pkg::*;

    word_t imm;

    always_comb
    begin
        if (i_is_jal)
            imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
        else if (i_is_lui || i_is_auipc)
            imm = {i_instr[31:12], 12'h000};
        else if (i_is_jalr || i_is_load || i_is_op_imm)
            imm = {{21{i_instr[31]}}, i_instr[30:20]};
        else if (i_is_branch)
            imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
        else if (i_is_store)
            imm = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
        else
            imm = '0;
    end

    assign o_imm = imm;

endmodule

// ==== hw/rv_ctrl_gen.sv ====
`timescale 1ns/1ps

module rv_ctrl_gen
(
    input  rv_decode_pkg::instr_t    i_instr,
    input  logic                     i_is_load,
    input  logic                     i_is_store,
    input  logic                     i_is_op_imm,
    input  logic                     i_is_op_reg,
    input  logic                     i_is_branch,
    input  logic                     i_is_jal,
    input  logic                     i_is_jalr,
    input  logic                     i_is_lui,
    input  logic                     i_is_auipc,
    output rv_decode_pkg::alu_ctrl_t o_alu_ctrl,
    output rv_decode_pkg::res_src_t  o_res_src,
    output logic                     o_reg_write,
    output logic                     o_mem_read,
    output logic                     o_mem_write,
    output logic                     o_jump,
    output logic                     o_branch,
    output logic                     o_pc_sel,
    output logic                     o_alu_op1_sel,
    output logic                     o_alu_op2_sel
);

    import rv_decode_pkg::*;

    funct3_t    funct3;
    logic       alt;
    logic       is_arith;
    logic       arith_shift;
    logic [3:0] alu_op;

    assign funct3   = i_instr[14:12];
    assign alt      = i_instr[30];
    assign is_arith = i_is_op_imm || i_is_op_reg;
    // sra and srai
    assign arith_shift = is_arith && (funct3 == 3'b101) && alt;

    always_comb
    begin
        alu_op = ALU_ADD;
        if (i_is_branch)
        begin
            case (funct3)
                3'b000:  alu_op = ALU_CMP_EQ;
                3'b001:  alu_op = ALU_CMP_NEQ;
                3'b100:  alu_op = ALU_CMP_LTS;
                3'b101:  alu_op = ALU_CMP_NLTS;
                3'b110:  alu_op = ALU_CMP_LTU;
                3'b111:  alu_op = ALU_CMP_NLTU;
                default: alu_op = ALU_ADD;
            endcase
        end
        else if (is_arith)
        begin
            case (funct3)
                // bit 30 on addi is immediate data, so sub is register only
                3'b000:  alu_op = (i_is_op_reg && alt) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SHL;
                3'b010:  alu_op = ALU_CMP_LTS;
                3'b011:  alu_op = ALU_CMP_LTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = ALU_SHR;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    assign o_alu_ctrl = {arith_shift, alu_op};

    assign o_res_src = i_is_load ? RES_SRC_MEM :
                       (i_is_jal || i_is_jalr) ? RES_SRC_PC_P4 : RES_SRC_ALU;

    assign o_alu_op1_sel = (i_is_auipc || i_is_jal) ? OP1_SEL_PC : OP1_SEL_REG;
    assign o_alu_op2_sel = (i_is_auipc || i_is_jal || i_is_jalr || i_is_lui || i_is_op_imm ||
                            i_is_load || i_is_store) ? OP2_SEL_IMM : OP2_SEL_REG;

    assign o_reg_write = i_is_load || is_arith || i_is_auipc || i_is_lui || i_is_jal || i_is_jalr;
    assign o_mem_read  = i_is_load;
    assign o_mem_write = i_is_store;
    assign o_jump      = i_is_jal || i_is_jalr;
    assign o_branch    = i_is_branch;
    // jalr target comes from a register
    assign o_pc_sel    = i_is_jalr;

endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode
(
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_stall,
    input  logic                      i_flush,
    input  rv_decode_pkg::instr_t     i_data,
    input  rv_decode_pkg::pc_t        i_pc,
    input  rv_decode_pkg::pc_t        i_pc_p4,
    output rv_decode_pkg::reg_idx_t   o_rs1,
    output rv_decode_pkg::reg_idx_t   o_rs2,
    output rv_decode_pkg::reg_idx_t   o_rd,
    output rv_decode_pkg::pc_t        o_pc,
    output rv_decode_pkg::pc_t        o_pc_p4,
    output rv_decode_pkg::word_t      o_imm,
    output logic                      o_reg_write,
    output logic                      o_mem_read,
    output logic                      o_mem_write,
    output rv_decode_pkg::res_src_t   o_res_src,
    output logic                      o_pc_sel,
    output logic                      o_jump,
    output logic                      o_branch,
    output logic                      o_alu_op1_sel,
    output logic                      o_alu_op2_sel,
    output rv_decode_pkg::funct3_t    o_funct3,
    output rv_decode_pkg::alu_ctrl_t  o_alu_ctrl,
    output logic                      o_inv_instr
);

    import rv_decode_pkg::*;

    instr_t sel_instr;
    logic   is_load;
    logic   is_store;
    logic   is_op_imm;
    logic   is_op_reg;
    logic   is_branch;
    logic   is_jal;
    logic   is_jalr;
    logic   is_lui;
    logic   is_auipc;

    rv_instr_hold u_hold
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_data  (i_data),
        .i_pc    (i_pc),
        .i_pc_p4 (i_pc_p4),
        .o_instr (sel_instr),
        .o_pc    (o_pc),
        .o_pc_p4 (o_pc_p4)
    );

    rv_instr_class u_class
    (
        .i_instr     (sel_instr),
        .o_rs1       (o_rs1),
        .o_rs2       (o_rs2),
        .o_rd        (o_rd),
        .o_funct3    (o_funct3),
        .o_is_load   (is_load),
        .o_is_store  (is_store),
        .o_is_op_imm (is_op_imm),
        .o_is_op_reg (is_op_reg),
        .o_is_branch (is_branch),
        .o_is_jal    (is_jal),
        .o_is_jalr   (is_jalr),
        .o_is_lui    (is_lui),
        .o_is_auipc  (is_auipc),
        .o_inv_instr (o_inv_instr)
    );

    rv_imm_gen u_imm
    (
        .i_instr     (sel_instr),
        .i_is_load   (is_load),
        .i_is_store  (is_store),
        .i_is_op_imm (is_op_imm),
        .i_is_branch (is_branch),
        .i_is_jal    (is_jal),
        .i_is_jalr   (is_jalr),
        .i_is_lui    (is_lui),
        .i_is_auipc  (is_auipc),
        .o_imm       (o_imm)
    );

    rv_ctrl_gen u_ctrl
    (
        .i_instr       (sel_instr),
        .i_is_load     (is_load),
        .i_is_store    (is_store),
        .i_is_op_imm   (is_op_imm),
        .i_is_op_reg   (is_op_reg),
        .i_is_branch   (is_branch),
        .i_is_jal      (is_jal),
        .i_is_jalr     (is_jalr),
        .i_is_lui      (is_lui),
        .i_is_auipc    (is_auipc),
        .o_alu_ctrl    (o_alu_ctrl),
        .o_res_src     (o_res_src),
        .o_reg_write   (o_reg_write),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_jump        (o_jump),
        .o_branch      (o_branch),
        .o_pc_sel      (o_pc_sel),
        .o_alu_op1_sel (o_alu_op1_sel),
        .o_alu_op2_sel (o_alu_op2_sel)
    );

endmodule

// ==== tb/rv_decode_vectors.svh ====
`ifndef RV_DECODE_VECTORS_SVH
`define RV_DECODE_VECTORS_SVH

// each entry holds name, word, imm, alu_ctrl, res_src, rs1, rs2, rd, funct3 and flags
// flag bits from the top are reg_write mem_read mem_write jump branch pc_sel op1 op2 inv
task automatic fill_table();
    add_vec("addi -1",   32'hFFF10093, 32'hFFFFFFFF, 5'h00, 2'd0, 5'd2,  5'd31, 5'd1,  3'd0,
            9'b100000010);
    add_vec("srai 5",    32'h40515093, 32'h00000405, 5'h16, 2'd0, 5'd2,  5'd5,  5'd1,  3'd5,
            9'b100000010);
    add_vec("slti 100",  32'h06412093, 32'h00000064, 5'h0A, 2'd0, 5'd2,  5'd4,  5'd1,  3'd2,
            9'b100000010);
    add_vec("slli 31",   32'h01F11093, 32'h0000001F, 5'h05, 2'd0, 5'd2,  5'd31, 5'd1,  3'd1,
            9'b100000010);
    add_vec("sub",       32'h403100B3, 32'h00000000, 5'h01, 2'd0, 5'd2,  5'd3,  5'd1,  3'd0,
            9'b100000000);
    add_vec("sltu",      32'h003130B3, 32'h00000000, 5'h0B, 2'd0, 5'd2,  5'd3,  5'd1,  3'd3,
            9'b100000000);
    add_vec("sra",       32'h403150B3, 32'h00000000, 5'h16, 2'd0, 5'd2,  5'd3,  5'd1,  3'd5,
            9'b100000000);
    add_vec("xor",       32'h003140B3, 32'h00000000, 5'h02, 2'd0, 5'd2,  5'd3,  5'd1,  3'd4,
            9'b100000000);
    add_vec("lw -4",     32'hFFC12083, 32'hFFFFFFFC, 5'h00, 2'd1, 5'd2,  5'd28, 5'd1,  3'd2,
            9'b110000010);
    add_vec("lbu 8",     32'h00814083, 32'h00000008, 5'h00, 2'd1, 5'd2,  5'd8,  5'd1,  3'd4,
            9'b110000010);
    add_vec("sw -8",     32'hFE312C23, 32'hFFFFFFF8, 5'h00, 2'd0, 5'd2,  5'd3,  5'd24, 3'd2,
            9'b001000010);
    add_vec("sb 20",     32'h00310A23, 32'h00000014, 5'h00, 2'd0, 5'd2,  5'd3,  5'd20, 3'd0,
            9'b001000010);
    add_vec("beq -16",   32'hFE3108E3, 32'hFFFFFFF0, 5'h08, 2'd0, 5'd2,  5'd3,  5'd17, 3'd0,
            9'b000010000);
    add_vec("bltu 32",   32'h02316063, 32'h00000020, 5'h0B, 2'd0, 5'd2,  5'd3,  5'd0,  3'd6,
            9'b000010000);
    add_vec("lui",       32'h123450B7, 32'h12345000, 5'h00, 2'd0, 5'd0,  5'd3,  5'd1,  3'd5,
            9'b100000010);
    add_vec("auipc",     32'hFFFFF097, 32'hFFFFF000, 5'h00, 2'd0, 5'd31, 5'd31, 5'd1,  3'd7,
            9'b100000110);
    add_vec("jal -2048", 32'h801FF0EF, 32'hFFFFF800, 5'h00, 2'd2, 5'd31, 5'd1,  5'd1,  3'd7,
            9'b100100110);
    add_vec("jal 16",    32'h010000EF, 32'h00000010, 5'h00, 2'd2, 5'd0,  5'd16, 5'd1,  3'd0,
            9'b100100110);
    add_vec("jalr 12",   32'h00C100E7, 32'h0000000C, 5'h00, 2'd2, 5'd2,  5'd12, 5'd1,  3'd0,
            9'b100101010);
    add_vec("fence",     32'h0FF0000F, 32'h00000000, 5'h00, 2'd0, 5'd0,  5'd31, 5'd0,  3'd0,
            9'b000000000);
    add_vec("zero",      32'h00000000, 32'h00000000, 5'h00, 2'd0, 5'd0,  5'd0,  5'd0,  3'd0,
            9'b000000000);
    // words below must be rejected
    add_vec("ecall",     32'h00000073, 32'h00000000, 5'h00, 2'd0, 5'd0,  5'd0,  5'd0,  3'd0,
            9'b000000001);
    add_vec("op f7 01",  32'h023100B3, 32'h00000000, 5'h00, 2'd0, 5'd2,  5'd3,  5'd1,  3'd0,
            9'b000000001);
    add_vec("c.li",      32'h00004501, 32'h00000000, 5'h00, 2'd0, 5'd0,  5'd0,  5'd10, 3'd4,
            9'b000000001);
    add_vec("load f3 3", 32'hFFC13083, 32'h00000000, 5'h00, 2'd0, 5'd2,  5'd28, 5'd1,  3'd3,
            9'b000000001);
endtask

`endif

// ==== tb/tb_rv_decode.sv ====
`timescale 1ns/1ps

module tb_rv_decode;

    import rv_decode_pkg::*;

    localparam int MAX_VEC    = 32;
    localparam int SEQ_CYCLES = 15;
    localparam int IDX_ADDI   = 0;
    localparam int IDX_SUB    = 4;
    localparam int IDX_LW     = 8;

    logic       i_clk;
    logic       i_reset;
    logic       i_stall;
    logic       i_flush;
    instr_t     i_data;
    pc_t        i_pc;
    pc_t        i_pc_p4;
    reg_idx_t   o_rs1;
    reg_idx_t   o_rs2;
    reg_idx_t   o_rd;
    pc_t        o_pc;
    pc_t        o_pc_p4;
    word_t      o_imm;
    logic       o_reg_write;
    logic       o_mem_read;
    logic       o_mem_write;
    res_src_t   o_res_src;
    logic       o_pc_sel;
    logic       o_jump;
    logic       o_branch;
    logic       o_alu_op1_sel;
    logic       o_alu_op2_sel;
    funct3_t    o_funct3;
    alu_ctrl_t  o_alu_ctrl;
    logic       o_inv_instr;

    string       vec_name[MAX_VEC];
    logic [31:0] vec_instr[MAX_VEC];
    logic [31:0] vec_imm[MAX_VEC];
    logic [4:0]  vec_alu[MAX_VEC];
    logic [1:0]  vec_res[MAX_VEC];
    logic [4:0]  vec_rs1[MAX_VEC];
    logic [4:0]  vec_rs2[MAX_VEC];
    logic [4:0]  vec_rd[MAX_VEC];
    logic [2:0]  vec_f3[MAX_VEC];
    logic [8:0]  vec_flags[MAX_VEC];
    int          n_vec;

    integer seed;
    int     cycle_cnt;
    int     cycle_limit;
    int     n_checks;
    int     n_errors;
    int     test_errs;
    int     n_tests;
    string  test_name;
    pc_t    last_pc;
    pc_t    held_pc;

    rv_decode dut
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_data        (i_data),
        .i_pc          (i_pc),
        .i_pc_p4       (i_pc_p4),
        .o_rs1         (o_rs1),
        .o_rs2         (o_rs2),
        .o_rd          (o_rd),
        .o_pc          (o_pc),
        .o_pc_p4       (o_pc_p4),
        .o_imm         (o_imm),
        .o_reg_write   (o_reg_write),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_res_src     (o_res_src),
        .o_pc_sel      (o_pc_sel),
        .o_jump        (o_jump),
        .o_branch      (o_branch),
        .o_alu_op1_sel (o_alu_op1_sel),
        .o_alu_op2_sel (o_alu_op2_sel),
        .o_funct3      (o_funct3),
        .o_alu_ctrl    (o_alu_ctrl),
        .o_inv_instr   (o_inv_instr)
    );

    task automatic add_vec(input string name, input logic [31:0] instr,
                           input logic [31:0] imm, input logic [4:0] alu,
                           input logic [1:0] res, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [4:0] rd,
                           input logic [2:0] funct3, input logic [8:0] flags);
        vec_name[n_vec]  = name;
        vec_instr[n_vec] = instr;
        vec_imm[n_vec]   = imm;
        vec_alu[n_vec]   = alu;
        vec_res[n_vec]   = res;
        vec_rs1[n_vec]   = rs1;
        vec_rs2[n_vec]   = rs2;
        vec_rd[n_vec]    = rd;
        vec_f3[n_vec]    = funct3;
        vec_flags[n_vec] = flags;
        n_vec = n_vec + 1;
    endtask

    `include "rv_decode_vectors.svh"

    initial
    begin
        i_clk = 1'b0;
        forever
        begin
            #20 i_clk = ~i_clk;
        end
    end

    always @(posedge i_clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
        begin
            $display("timeout after %0d cycles in test %s", cycle_cnt, test_name);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        n_checks = n_checks + 1;
        if (exp_v !== act_v)
        begin
            $display("ERR %s expected %h got %h (%s)", name, exp_v, act_v, test_name);
            n_errors  = n_errors + 1;
            test_errs = test_errs + 1;
        end
    endtask

    function automatic logic [8:0] flag_vec();
        return {o_reg_write, o_mem_read, o_mem_write, o_jump, o_branch, o_pc_sel,
                o_alu_op1_sel, o_alu_op2_sel, o_inv_instr};
    endfunction

    task automatic check_entry(input int idx);
        check_val("o_imm", vec_imm[idx], o_imm);
        check_val("o_alu_ctrl", 32'(vec_alu[idx]), 32'(o_alu_ctrl));
        check_val("o_res_src", 32'(vec_res[idx]), 32'(o_res_src));
        check_val("o_rs1", 32'(vec_rs1[idx]), 32'(o_rs1));
        check_val("o_rs2", 32'(vec_rs2[idx]), 32'(o_rs2));
        check_val("o_rd", 32'(vec_rd[idx]), 32'(o_rd));
        check_val("o_funct3", 32'(vec_f3[idx]), 32'(o_funct3));
        check_val("flags", 32'(vec_flags[idx]), 32'(flag_vec()));
    endtask

    // decode of a bubble
    task automatic check_idle();
        check_val("o_imm", 32'h0, o_imm);
        check_val("o_alu_ctrl", 32'h0, 32'(o_alu_ctrl));
        check_val("o_res_src", 32'h0, 32'(o_res_src));
        check_val("flags", 32'h0, 32'(flag_vec()));
    endtask

    // drive on the falling edge and sample just before the rising edge
    task automatic step(input logic [31:0] instr, input logic stall, input logic flush);
        logic [31:0] rnd;
        @(negedge i_clk);
        rnd     = $random(seed);
        i_data  = instr;
        i_stall = stall;
        i_flush = flush;
        i_pc    = rnd[31:2];
        i_pc_p4 = rnd[31:2] + 30'd1;
        last_pc = rnd[31:2];
        #15;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        n_tests = n_tests + 1;
        if (test_errs == 0)
            $display("%-14s ok", test_name);
        else
            $display("%-14s %0d mismatches", test_name, test_errs);
    endtask

    initial
    begin
        i_reset   = 1'b1;
        i_stall   = 1'b0;
        i_flush   = 1'b0;
        i_data    = '0;
        i_pc      = '0;
        i_pc_p4   = '0;
        seed      = 32'h905e;
        n_vec     = 0;
        cycle_cnt = 0;
        n_checks  = 0;
        n_errors  = 0;
        n_tests   = 0;
        fill_table();
        cycle_limit = (n_vec + SEQ_CYCLES) * 2 + 20;

        // reset spans the first three clock periods
        start_test("reset");
        repeat (2)
        begin
            step(vec_instr[IDX_ADDI], 1'b0, 1'b0);
            check_idle();
            check_val("o_pc", 32'h0, 32'(o_pc));
        end
        end_test();
        @(negedge i_clk);
        i_reset = 1'b0;

        for (int i = 0; i < n_vec; i++)
        begin
            start_test(vec_name[i]);
            step(vec_instr[i], 1'b0, 1'b0);
            check_entry(i);
            end_test();
        end

        start_test("pc path");
        step(vec_instr[IDX_ADDI], 1'b0, 1'b0);
        held_pc = last_pc;
        step(vec_instr[IDX_ADDI], 1'b1, 1'b0);
        check_val("o_pc", 32'(held_pc), 32'(o_pc));
        check_val("o_pc_p4", 32'(held_pc + 30'd1), 32'(o_pc_p4));
        step(vec_instr[IDX_ADDI], 1'b0, 1'b0);
        check_val("o_pc", 32'(held_pc), 32'(o_pc));
        held_pc = last_pc;
        step(vec_instr[IDX_ADDI], 1'b0, 1'b0);
        check_val("o_pc", 32'(held_pc), 32'(o_pc));
        check_val("o_pc_p4", 32'(held_pc + 30'd1), 32'(o_pc_p4));
        end_test();

        // word A is on i_data in the first stalled cycle
        start_test("stall hold");
        step(vec_instr[IDX_LW], 1'b1, 1'b0);
        check_entry(IDX_LW);
        step(vec_instr[IDX_SUB], 1'b1, 1'b0);
        check_entry(IDX_LW);
        step(vec_instr[IDX_ADDI], 1'b1, 1'b0);
        check_entry(IDX_LW);
        // held word is still consumed in the cycle the stall drops
        step(vec_instr[IDX_ADDI], 1'b0, 1'b0);
        check_entry(IDX_LW);
        step(vec_instr[IDX_SUB], 1'b0, 1'b0);
        check_entry(IDX_SUB);
        end_test();

        start_test("flush");
        step(vec_instr[IDX_LW], 1'b0, 1'b1);
        step(vec_instr[IDX_LW], 1'b0, 1'b0);
        check_idle();
        check_val("o_pc", 32'h0, 32'(o_pc));
        held_pc = last_pc;
        step(vec_instr[IDX_LW], 1'b0, 1'b0);
        check_entry(IDX_LW);
        check_val("o_pc", 32'(held_pc), 32'(o_pc));
        end_test();

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+tb
hw/rv_decode_pkg.sv
hw/rv_instr_hold.sv
hw/rv_instr_class.sv
hw/rv_imm_gen.sv
hw/rv_ctrl_gen.sv
hw/rv_decode.sv
tb/tb_rv_decode.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary -f tb.f --top-module tb_rv_decode -o tb_sim
	@out=$$(./obj_dir/tb_sim); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
